/* rtl/sme_pkg.sv */
/*
 * Shared constants for the masked AES instruction unit:
 * share and width counts, randomness sizing, affine and MixColumn constants, LFSR seeds
 */

`default_nettype none

package sme_pkg;

    // Datapath and masking -------------------------------------------------
    localparam int XLEN       = 32;                      // Operand width
    localparam int SMAX       = 3;                       // Hardware shares, fixed at build
    localparam int NCROSS     = SMAX * (SMAX - 1) / 2;   // Random bytes per masked mul
    localparam int RMAX       = SMAX + NCROSS;           // Random words per cycle
    localparam int SBOX_STEPS = 4;                       // Masked muls per S-box pass

    // AES affine constants, added to share 0 only
    localparam logic [7:0] AFFINE_C     = 8'h63;
    localparam logic [7:0] INV_AFFINE_C = 8'h05;

    // MixColumn coefficients, nibble 3 is the high byte of the column word
    localparam logic [15:0] MIX_FWD = {4'd3, 4'd1, 4'd1, 4'd2};
    localparam logic [15:0] MIX_INV = {4'd11, 4'd13, 4'd9, 4'd14};

    // ----------------------------------------------------------------------
    // RNG bank
    // ----------------------------------------------------------------------

    // Right-shift Galois taps for x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] LFSR_POLY = 32'h8020_0003;

    // Reset seeds, one per lane, all nonzero
    localparam logic [RMAX-1:0][31:0] RNG_SEED = {
        32'h6d2b_79f5,   // Lane 5
        32'h1f83_d9ab,   // Lane 4
        32'h5be0_cd19,   // Lane 3
        32'ha54f_f53a,   // Lane 2
        32'h3c6e_f372,   // Lane 1
        32'hbb67_ae85    // Lane 0
    };

endpackage

`default_nettype wire

/* rtl/sme_rng.sv */
/*
 * Bank of RMAX 32-bit Galois LFSRs, one fresh word per lane every cycle
 */

`timescale 1ns/1ps
`default_nettype none

module sme_rng (
    input  logic                     g_clk,
    input  logic                     arst_n,
    output logic [sme_pkg::XLEN-1:0] rng [sme_pkg::RMAX]   // Lane outputs
);

    logic [31:0] lfsr [sme_pkg::RMAX];

    // ----------------------------------------------------------------------
    // Lanes
    // ----------------------------------------------------------------------

    for (genvar i = 0; i < sme_pkg::RMAX; i++) begin : g_lane
        always_ff @(posedge g_clk or negedge arst_n) begin
            if (!arst_n) begin
                lfsr[i] <= sme_pkg::RNG_SEED[i];   // Distinct seed per lane
            end else begin
                // Shift right, fold taps in on a one out
                lfsr[i] <= {1'b0, lfsr[i][31:1]} ^ (lfsr[i][0] ? sme_pkg::LFSR_POLY : 32'h0);
            end
        end

        assign rng[i] = lfsr[i];
    end

endmodule

`default_nettype wire

/* rtl/sme_dom_mul.sv */
/*
 * Masked GF(2^8) multiplier over SMAX Boolean shares, combinational,
 * cross products refreshed with one random byte per share pair
 */

`timescale 1ns/1ps
`default_nettype none

module sme_dom_mul (
    input  logic [7:0] a   [sme_pkg::SMAX],   // Shares of first operand
    input  logic [7:0] b   [sme_pkg::SMAX],   // Shares of second operand
    input  logic [7:0] rnd [sme_pkg::NCROSS], // Fresh bytes, one per pair
    output logic [7:0] p   [sme_pkg::SMAX]    // Shares of the product
);

    // Multiply by x modulo the AES polynomial
    function automatic logic [7:0] xtime(input logic [7:0] v);
        return {v[6:0], 1'b0} ^ (v[7] ? 8'h1b : 8'h00);
    endfunction

    // Shift-and-add multiply in GF(2^8)
    function automatic logic [7:0] gf_mul(input logic [7:0] x, input logic [7:0] y);
        logic [7:0] acc;
        logic [7:0] sh;
        acc = 8'h00;
        sh  = x;
        for (int n = 0; n < 8; n++) begin
            if (y[n]) begin
                acc = acc ^ sh;   // Add term for this bit of y
            end
            sh = xtime(sh);
        end
        return acc;
    endfunction

    // ----------------------------------------------------------------------
    // Domain products
    // ----------------------------------------------------------------------

    always_comb begin
        int k;                          // Pair index into rnd
        k = 0;

        // Diagonal terms stay in their own share
        for (int i = 0; i < sme_pkg::SMAX; i++) begin
            p[i] = gf_mul(a[i], b[i]);
        end

        // Pair (i,j) shares one random byte; it cancels in the XOR of all shares
        for (int i = 0; i < sme_pkg::SMAX; i++) begin
            for (int j = i + 1; j < sme_pkg::SMAX; j++) begin
                p[i] = p[i] ^ gf_mul(a[i], b[j]) ^ rnd[k];
                p[j] = p[j] ^ gf_mul(a[j], b[i]) ^ rnd[k];
                k    = k + 1;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/sme_sbox_aes.sv */
/*
 * Multi-cycle masked AES S-box, forward and inverse
 * Inversion as x^254 with share-wise squarings and one masked mul per step
 */

`timescale 1ns/1ps
`default_nettype none

module sme_sbox_aes (
    input  logic                     g_clk,
    input  logic                     arst_n,
    input  logic                     en,                        // Request active
    input  logic                     flush,                     // Abort and restart
    input  logic                     dec,                       // Inverse S-box
    input  logic [sme_pkg::XLEN-1:0] rng      [sme_pkg::RMAX],  // Fresh words
    input  logic [7:0]               sbox_in  [sme_pkg::SMAX],
    output logic [7:0]               sbox_out [sme_pkg::SMAX],
    output logic                     done                       // Step 3, result valid
);

    // Squaring in GF(2^8), linear so it works per share
    function automatic logic [7:0] gf_sq(input logic [7:0] v);
        return {v[6] ^ v[7],
                v[3] ^ v[5],
                v[5] ^ v[6],
                v[2] ^ v[4] ^ v[7],
                v[4] ^ v[5] ^ v[6] ^ v[7],
                v[1] ^ v[5],
                v[4] ^ v[6] ^ v[7],
                v[0] ^ v[4] ^ v[6]};
    endfunction

    // Linear part of the forward affine map
    function automatic logic [7:0] aff_lin(input logic [7:0] v);
        return v ^ {v[6:0], v[7]} ^ {v[5:0], v[7:6]} ^ {v[4:0], v[7:5]} ^ {v[3:0], v[7:4]};
    endfunction

    // Linear part of the inverse affine map
    function automatic logic [7:0] inv_aff_lin(input logic [7:0] v);
        return {v[6:0], v[7]} ^ {v[4:0], v[7:5]} ^ {v[1:0], v[7:2]};
    endfunction

    logic [1:0] step;                         // Current multiplication
    logic [7:0] x_in   [sme_pkg::SMAX];       // x after optional inverse affine
    logic [7:0] x2     [sme_pkg::SMAX];
    logic [7:0] x12    [sme_pkg::SMAX];
    logic [7:0] x240   [sme_pkg::SMAX];
    logic [7:0] x3_r   [sme_pkg::SMAX];       // Step 0 product
    logic [7:0] prod_r [sme_pkg::SMAX];       // Step 1 and 2 products
    logic [7:0] mul_a  [sme_pkg::SMAX];
    logic [7:0] mul_b  [sme_pkg::SMAX];
    logic [7:0] mul_p  [sme_pkg::SMAX];
    logic [7:0] rnd    [sme_pkg::NCROSS];

    // Share-wise linear layers ---------------------------------------------
    for (genvar s = 0; s < sme_pkg::SMAX; s++) begin : g_share
        assign x_in[s] = dec ? inv_aff_lin(sbox_in[s]) ^ ((s == 0) ? sme_pkg::INV_AFFINE_C : 8'h00)
                             : sbox_in[s];
        assign x2[s]   = gf_sq(x_in[s]);
        assign x12[s]  = gf_sq(gf_sq(x3_r[s]));                       // (x^3)^4
        assign x240[s] = gf_sq(gf_sq(gf_sq(gf_sq(prod_r[s]))));       // (x^15)^16

        // Forward affine on the way out; the constant goes into one share only
        assign sbox_out[s] = dec ? mul_p[s]
                                 : aff_lin(mul_p[s]) ^ ((s == 0) ? sme_pkg::AFFINE_C : 8'h00);
    end

    // One byte per pair, a different byte each step
    for (genvar k = 0; k < sme_pkg::NCROSS; k++) begin : g_rnd
        assign rnd[k] = rng[k][{step, 3'b000} +: 8];
    end

    // Operand select for the single multiplier
    always_comb begin
        for (int s = 0; s < sme_pkg::SMAX; s++) begin
            case (step)
                2'd0: begin                   // x^3
                    mul_a[s] = x2[s];
                    mul_b[s] = x_in[s];
                end
                2'd1: begin                   // x^15
                    mul_a[s] = x12[s];
                    mul_b[s] = x3_r[s];
                end
                2'd2: begin                   // x^252
                    mul_a[s] = x240[s];
                    mul_b[s] = x12[s];
                end
                default: begin                // x^254
                    mul_a[s] = prod_r[s];
                    mul_b[s] = x2[s];
                end
            endcase
        end
    end

    sme_dom_mul u_mul (
        .a   (mul_a),
        .b   (mul_b),
        .rnd (rnd),
        .p   (mul_p)
    );

    assign done = en && (step == 2'(sme_pkg::SBOX_STEPS - 1)) && !flush;

    // ----------------------------------------------------------------------
    // Step counter and product registers
    // ----------------------------------------------------------------------

    always_ff @(posedge g_clk or negedge arst_n) begin
        if (!arst_n) begin
            step <= 2'd0;
        end else if (flush || done) begin
            step <= 2'd0;                 // Restart or finish
        end else if (en) begin
            step <= step + 2'd1;
        end
    end

    always_ff @(posedge g_clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int s = 0; s < sme_pkg::SMAX; s++) begin
                x3_r[s]   <= 8'h00;
                prod_r[s] <= 8'h00;
            end
        end else begin
            if (en && step == 2'd0) begin
                x3_r <= mul_p;
            end
            if (en && (step == 2'd1 || step == 2'd2)) begin
                prod_r <= mul_p;          // x^15, then x^252
            end
        end
    end

    // Counter holds when idle
    a_step_hold : assert property (@(posedge g_clk) disable iff (!arst_n)
        (!en && !flush) |=> $stable(step));

    a_done_en : assert property (@(posedge g_clk) disable iff (!arst_n)
        !en |-> !done);

endmodule

`default_nettype wire

/* rtl/sme_crypto.sv */
/*
 * AES instruction datapath over SMAX shares
 * Byte select, masked S-box, MixColumn, byte rotation and rs1 XOR
 */

`timescale 1ns/1ps
`default_nettype none

module sme_crypto (
    input  logic                     g_clk,
    input  logic                     arst_n,
    input  logic [sme_pkg::XLEN-1:0] rng [sme_pkg::RMAX],   // Fresh randomness
    input  logic                     flush,                 // Discard op in flight
    input  logic                     valid,
    output logic                     ready,                 // One-cycle result pulse
    input  logic                     op_aeses,
    input  logic                     op_aesesm,
    input  logic                     op_aesds,
    input  logic                     op_aesdsm,
    input  logic [1:0]               bs,                    // AES byte select
    input  logic [sme_pkg::XLEN-1:0] rs1 [sme_pkg::SMAX],
    input  logic [sme_pkg::XLEN-1:0] rs2 [sme_pkg::SMAX],
    output logic [sme_pkg::XLEN-1:0] rd  [sme_pkg::SMAX]
);

    // Multiply by x modulo 8'h1b
    function automatic logic [7:0] xtime(input logic [7:0] v);
        return {v[6:0], 1'b0} ^ (v[7] ? 8'h1b : 8'h00);
    endfunction

    // Multiply by a 4-bit constant, enough for MixColumn
    function automatic logic [7:0] mul_c(input logic [7:0] v, input logic [3:0] c);
        return (c[0] ? v : 8'h00)
             ^ (c[1] ? xtime(v) : 8'h00)
             ^ (c[2] ? xtime(xtime(v)) : 8'h00)
             ^ (c[3] ? xtime(xtime(xtime(v))) : 8'h00);
    endfunction

    // Rotate left by whole bytes
    function automatic logic [31:0] rotl_b(input logic [31:0] w, input logic [1:0] n);
        case (n)
            2'd0:    return w;
            2'd1:    return {w[23:0], w[31:24]};
            2'd2:    return {w[15:0], w[31:16]};
            default: return {w[7:0], w[31:8]};
        endcase
    endfunction

    // ----------------------------------------------------------------------
    // Decode
    // ----------------------------------------------------------------------

    logic       aes_any;                     // Any AES op strobe
    logic       aes_en;
    logic       aes_dec;                     // Inverse direction
    logic       aes_mix;                     // Expand to column word
    logic       sbox_done;
    logic [7:0] sbox_in  [sme_pkg::SMAX];
    logic [7:0] sbox_out [sme_pkg::SMAX];

    assign aes_any = op_aeses || op_aesesm || op_aesds || op_aesdsm;
    assign aes_en  = valid && aes_any;
    assign aes_dec = op_aesds || op_aesdsm;
    assign aes_mix = op_aesesm || op_aesdsm;
    assign ready   = valid && aes_any && sbox_done;

    // Per-share datapath ---------------------------------------------------
    for (genvar s = 0; s < sme_pkg::SMAX; s++) begin : g_share
        logic [31:0] mix_w;                  // MixColumn word
        logic [31:0] col_w;                  // Word before rotation

        assign sbox_in[s] = rs2[s][{bs, 3'b000} +: 8];

        for (genvar b = 0; b < 4; b++) begin : g_byte
            assign mix_w[8*b +: 8] = mul_c(sbox_out[s], aes_dec ? sme_pkg::MIX_INV[4*b +: 4]
                                                                : sme_pkg::MIX_FWD[4*b +: 4]);
        end

        assign col_w = aes_mix ? mix_w : {24'h000000, sbox_out[s]};
        assign rd[s] = rotl_b(col_w, bs) ^ rs1[s];       // Share-wise, stays masked
    end

    sme_sbox_aes u_sbox (
        .g_clk    (g_clk),
        .arst_n   (arst_n),
        .en       (aes_en),
        .flush    (flush),
        .dec      (aes_dec),
        .rng      (rng),
        .sbox_in  (sbox_in),
        .sbox_out (sbox_out),
        .done     (sbox_done)
    );

    // ----------------------------------------------------------------------
    // Request checks
    // ----------------------------------------------------------------------

    a_op_onehot : assert property (@(posedge g_clk) disable iff (!arst_n)
        $onehot0({op_aeses, op_aesesm, op_aesds, op_aesdsm}));

    a_req_stable : assert property (@(posedge g_clk) disable iff (!arst_n)
        (valid && !ready) |=> $stable({bs, op_aeses, op_aesesm, op_aesds, op_aesdsm}));

    // Operand shares held until the result pulse
    for (genvar s = 0; s < sme_pkg::SMAX; s++) begin : g_chk
        a_rs2_stable : assert property (@(posedge g_clk) disable iff (!arst_n)
            (valid && !ready) |=> $stable(rs2[s]));
    end

endmodule

`default_nettype wire

/* rtl/sme_top.sv */
/*
 * Top of the masked AES instruction unit: RNG bank plus crypto datapath
 */

`timescale 1ns/1ps
`default_nettype none

module sme_top (
    input  logic                     g_clk,
    input  logic                     arst_n,
    input  logic                     flush,
    input  logic                     valid,
    output logic                     ready,
    input  logic                     op_aeses,
    input  logic                     op_aesesm,
    input  logic                     op_aesds,
    input  logic                     op_aesdsm,
    input  logic [1:0]               bs,
    input  logic [sme_pkg::XLEN-1:0] rs1 [sme_pkg::SMAX],
    input  logic [sme_pkg::XLEN-1:0] rs2 [sme_pkg::SMAX],
    output logic [sme_pkg::XLEN-1:0] rd  [sme_pkg::SMAX]
);

    logic [sme_pkg::XLEN-1:0] rng [sme_pkg::RMAX];   // Randomness to the S-box

    // ----------------------------------------------------------------------
    // Randomness source
    // ----------------------------------------------------------------------

    sme_rng u_rng (
        .g_clk  (g_clk),
        .arst_n (arst_n),
        .rng    (rng)
    );

    // ----------------------------------------------------------------------
    // AES instruction datapath
    // ----------------------------------------------------------------------

    sme_crypto u_crypto (
        .g_clk     (g_clk),
        .arst_n    (arst_n),
        .rng       (rng),
        .flush     (flush),
        .valid     (valid),
        .ready     (ready),
        .op_aeses  (op_aeses),
        .op_aesesm (op_aesesm),
        .op_aesds  (op_aesds),
        .op_aesdsm (op_aesdsm),
        .bs        (bs),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd)
    );

endmodule

`default_nettype wire

/* verification/tb_aes_model.svh */
/*
 * Reference AES model: GF(2^8) multiply and inverse,
 * forward and inverse S-box, MixColumn words, byte rotation
 */

`ifndef TB_AES_MODEL_SVH
`define TB_AES_MODEL_SVH
`default_nettype none

// Carry-less product, then reduce modulo x^8 + x^4 + x^3 + x + 1
function automatic logic [7:0] gf_times(input logic [7:0] a, input logic [7:0] b);
    logic [14:0] wide;
    wide = 15'h0;
    for (int i = 0; i < 8; i++) begin
        if (b[i]) begin
            wide = wide ^ (15'(a) << i);
        end
    end
    for (int i = 14; i >= 8; i--) begin
        if (wide[i]) begin
            wide = wide ^ (15'h11b << (i - 8));   // Fold top bit down
        end
    end
    return wide[7:0];
endfunction

// Exhaustive search for the inverse, 0 maps to 0
function automatic logic [7:0] gf_inverse(input logic [7:0] v);
    logic [7:0] r;
    r = 8'h00;
    for (int c = 1; c < 256; c++) begin
        if (gf_times(v, 8'(c)) == 8'h01) begin
            r = 8'(c);
        end
    end
    return r;
endfunction

function automatic logic [7:0] rotl8(input logic [7:0] v, input int n);
    return (v << n) | (v >> (8 - n));
endfunction

// Inverse, then affine map with constant 63
function automatic logic [7:0] sbox_fwd(input logic [7:0] v);
    logic [7:0] b;
    b = gf_inverse(v);
    return b ^ rotl8(b, 1) ^ rotl8(b, 2) ^ rotl8(b, 3) ^ rotl8(b, 4) ^ 8'h63;
endfunction

// Inverse affine map first, then inverse
function automatic logic [7:0] sbox_inv(input logic [7:0] v);
    return gf_inverse(rotl8(v, 1) ^ rotl8(v, 3) ^ rotl8(v, 6) ^ 8'h05);
endfunction

// Column word, high byte first
function automatic logic [31:0] mix_column(input logic [7:0] s, input logic inv);
    if (inv) begin
        return {gf_times(s, 8'd11), gf_times(s, 8'd13), gf_times(s, 8'd9), gf_times(s, 8'd14)};
    end
    return {gf_times(s, 8'd3), s, s, gf_times(s, 8'd2)};
endfunction

function automatic logic [31:0] rotl_bytes(input logic [31:0] w, input logic [1:0] n);
    return (w << (8 * n)) | (w >> (32 - 8 * n));   // n = 0 leaves w
endfunction

`default_nettype wire
`endif

/* verification/tb_sme_top.sv */
/*
 * Testbench for the masked AES instruction unit: random masked requests,
 * flush aborts, share-split and encrypt/decrypt round-trip checks
 */

`timescale 1ns/1ps
`include "tb_aes_model.svh"
`default_nettype none

module tb_sme_top;

    localparam int N_SBOX      = 24;                 // aeses and aesds
    localparam int N_MIX       = 24;                 // aesesm and aesdsm
    localparam int N_FLUSH     = 8;
    localparam int N_SPLIT     = 6;                  // Each sent three times
    localparam int N_REQ       = N_SBOX + N_MIX + N_FLUSH + 3 * N_SPLIT + 512;
    localparam int CYCLE_LIMIT = N_REQ * 6 + N_FLUSH * 10 + 100;

    logic                     g_clk;
    logic                     arst_n;
    logic                     flush;
    logic                     valid;
    logic                     ready;
    logic                     op_aeses;
    logic                     op_aesesm;
    logic                     op_aesds;
    logic                     op_aesdsm;
    logic [1:0]               bs;
    logic [sme_pkg::XLEN-1:0] rs1 [sme_pkg::SMAX];
    logic [sme_pkg::XLEN-1:0] rs2 [sme_pkg::SMAX];
    logic [sme_pkg::XLEN-1:0] rd  [sme_pkg::SMAX];

    logic [31:0] lfsr_state;                         // Stimulus LFSR
    logic [7:0]  sbox_tab  [256];
    logic [7:0]  isbox_tab [256];
    int          mismatches;
    int          failures;                           // Protocol and timing
    int          cycles;

    sme_top DUT (
        .g_clk (g_clk), .arst_n (arst_n), .flush (flush), .valid (valid), .ready (ready),
        .op_aeses (op_aeses), .op_aesesm (op_aesesm), .op_aesds (op_aesds),
        .op_aesdsm (op_aesdsm), .bs (bs), .rs1 (rs1), .rs2 (rs2), .rd (rd)
    );

    initial begin
        g_clk = 1'b0;
        forever #20 g_clk = ~g_clk;                  // 40 ns period
    end

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = 32'h0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r          = {r[30:0], fb};
        end
        return r;
    endfunction

    // Fresh random shares 1..SMAX-1, share 0 completes the XOR
    task automatic drive_shares(input logic [31:0] v1, input logic [31:0] v2);
        logic [31:0] acc1;
        logic [31:0] acc2;
        acc1 = v1;
        acc2 = v2;
        for (int s = 1; s < sme_pkg::SMAX; s++) begin
            rs1[s] = rand_bits(32);
            rs2[s] = rand_bits(32);
            acc1   = acc1 ^ rs1[s];
            acc2   = acc2 ^ rs2[s];
        end
        rs1[0] = acc1;
        rs2[0] = acc2;
    endtask

    function automatic logic [31:0] recombine_rd();
        logic [31:0] acc;
        acc = 32'h0;
        for (int s = 0; s < sme_pkg::SMAX; s++) begin
            acc = acc ^ rd[s];
        end
        return acc;
    endfunction

    // op 0 aeses, 1 aesesm, 2 aesds, 3 aesdsm
    function automatic logic [31:0] expected_rd(input int op, input logic [1:0] sel,
                                                input logic [31:0] v1, input logic [31:0] v2);
        logic [7:0]  sb;
        logic [31:0] col;
        sb  = (op >= 2) ? isbox_tab[v2[8 * sel +: 8]] : sbox_tab[v2[8 * sel +: 8]];
        col = ((op % 2) == 1) ? mix_column(sb, op >= 2) : {24'h0, sb};
        return v1 ^ rotl_bytes(col, sel);
    endfunction

    task automatic set_op(input int op);
        op_aeses  = (op == 0);
        op_aesesm = (op == 1);
        op_aesds  = (op == 2);
        op_aesdsm = (op == 3);
    endtask

    task automatic start_request(input int op, input logic [1:0] sel,
                                 input logic [31:0] v1, input logic [31:0] v2);
        @(negedge g_clk);
        valid = 1'b1;
        set_op(op);
        bs = sel;
        drive_shares(v1, v2);
    endtask

    // Rising edges until ready, bounded
    task automatic wait_ready(output int lat);
        lat = 0;
        do begin
            @(posedge g_clk);
            lat++;
        end while (!ready && lat < 12);
        if (!ready) begin
            $display("%0t: no ready pulse within 12 cycles", $time);
            failures++;
        end
    endtask

    task automatic check_result(input int op, input logic [1:0] sel, input logic [31:0] v1,
                                input logic [31:0] v2, input int lat, output logic [31:0] res);
        logic [31:0] exp_v;
        res   = recombine_rd();
        exp_v = expected_rd(op, sel, v1, v2);
        if (ready && lat != sme_pkg::SBOX_STEPS) begin
            $display("%0t: ready came in cycle %0d, not cycle %0d", $time, lat,
                     sme_pkg::SBOX_STEPS);
            failures++;
        end
        if (ready && res !== exp_v) begin
            $display("mismatch at %0t: op %0d bs %0d expected %h got %h", $time, op, sel,
                     exp_v, res);
            mismatches++;
        end
    endtask

    task automatic run_request(input int op, input logic [1:0] sel, input logic [31:0] v1,
                               input logic [31:0] v2, output logic [31:0] res);
        int lat;
        start_request(op, sel, v1, v2);
        wait_ready(lat);
        check_result(op, sel, v1, v2, lat, res);
    endtask

    // Flush in cycle 'at' of the request, then the held request restarts
    task automatic run_flushed(input int op, input logic [1:0] sel, input logic [31:0] v1,
                               input logic [31:0] v2, input int at);
        int          lat;
        logic [31:0] res;
        start_request(op, sel, v1, v2);
        for (int c = 1; c <= at; c++) begin
            flush = (c == at);
            @(posedge g_clk);
            if (ready) begin
                $display("%0t: ready appeared for a flushed request", $time);
                failures++;
            end
            @(negedge g_clk);
        end
        flush = 1'b0;
        wait_ready(lat);                             // Counted from the flush cycle
        check_result(op, sel, v1, v2, lat, res);
    endtask

    task automatic go_idle(input int n);
        repeat (n) begin
            @(negedge g_clk);
            valid = 1'b0;
        end
    endtask

    task automatic report_counts();
        $display("errors: %0d mismatches, %0d other failures, %0d cycles",
                 mismatches, failures, cycles);
    endtask

    // ----------------------------------------------------------------------
    // Watchdog and idle check
    // ----------------------------------------------------------------------

    always @(posedge g_clk) begin
        cycles++;
        if (arst_n && !valid && ready) begin
            $display("%0t: ready high while valid is low", $time);
            failures++;
        end
        if (cycles >= CYCLE_LIMIT) begin
            $display("%0t: timeout after %0d cycles", $time, cycles);
            report_counts();
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // ----------------------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------------------

    initial begin
        int          op;
        int          at;
        logic [1:0]  sel;
        logic [31:0] v1;
        logic [31:0] v2;
        logic [31:0] res;
        logic [31:0] res_alt;
        logic [31:0] plain;
        lfsr_state = 32'he3c5;
        mismatches = 0;
        failures   = 0;
        cycles     = 0;
        arst_n     = 1'b0;
        flush      = 1'b0;
        valid      = 1'b0;
        bs         = 2'd0;
        set_op(4);                                   // No strobe
        for (int s = 0; s < sme_pkg::SMAX; s++) begin
            rs1[s] = '0;
            rs2[s] = '0;
        end
        for (int v = 0; v < 256; v++) begin
            sbox_tab[v]  = sbox_fwd(8'(v));
            isbox_tab[v] = sbox_inv(8'(v));
        end
        repeat (8) @(negedge g_clk);
        arst_n = 1'b1;
        repeat (5) @(negedge g_clk);                 // Idle, ready must stay low

        for (int n = 0; n < N_SBOX; n++) begin
            op  = 2 * int'(rand_bits(1));
            sel = 2'(rand_bits(2));
            run_request(op, sel, rand_bits(32), rand_bits(32), res);
            go_idle(1);
        end
        for (int n = 0; n < N_MIX; n++) begin
            op  = 1 + 2 * int'(rand_bits(1));
            sel = 2'(rand_bits(2));
            run_request(op, sel, rand_bits(32), rand_bits(32), res);
            go_idle(1);
        end
        for (int n = 0; n < N_FLUSH; n++) begin
            op  = int'(rand_bits(2));
            sel = 2'(rand_bits(2));
            // First pass hits every step once, the last step included
            at  = (n < sme_pkg::SBOX_STEPS) ? n + 1 : 1 + int'(rand_bits(2));
            run_flushed(op, sel, rand_bits(32), rand_bits(32), at);
            go_idle(1);
        end

        // Same plain operands, three share splits
        for (int n = 0; n < N_SPLIT; n++) begin
            op  = int'(rand_bits(2));
            sel = 2'(rand_bits(2));
            v1  = rand_bits(32);
            v2  = rand_bits(32);
            run_request(op, sel, v1, v2, res);
            for (int k = 0; k < 2; k++) begin
                run_request(op, sel, v1, v2, res_alt);
                if (res_alt !== res) begin
                    $display("mismatch at %0t: share split changed rd, %h vs %h", $time,
                             res, res_alt);
                    mismatches++;
                end
            end
            go_idle(1);
        end

        // Encrypt then decrypt each byte, all back to back
        for (int b = 0; b < 256; b++) begin
            sel   = 2'(rand_bits(2));
            plain = rotl_bytes({24'h0, 8'(b)}, sel);
            run_request(0, sel, 32'h0, plain, res);
            run_request(2, sel, 32'h0, res, res_alt);
            if (res_alt !== plain) begin
                $display("mismatch at %0t: round trip of byte %h gave %h", $time, b, res_alt);
                mismatches++;
            end
        end
        go_idle(2);

        report_counts();
        if (mismatches == 0 && failures == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+verification
rtl/sme_pkg.sv
rtl/sme_rng.sv
rtl/sme_dom_mul.sv
rtl/sme_sbox_aes.sv
rtl/sme_crypto.sv
rtl/sme_top.sv
verification/tb_sme_top.sv

/* Makefile */
# Verilator build and run of the masked AES instruction unit testbench

VERILATOR ?= verilator
TOP       ?= tb_sme_top
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= PASS: all tests

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
